// ==== hw/perf_cfg.svh ====
/*
 * Build-time sizing for the memory performance monitor.
 * Lane count must be at least 1; counters wrap silently at
 * PERF_CTR_BITS. The report period is only a default, the top
 * level and timer take it as a parameter.
 */

`ifndef PERF_CFG_SVH
`define PERF_CFG_SVH

// data-cache lanes watched by the monitor
`define PERF_DCACHE_NUM_REQS 4

// width of every counter and pending value
`define PERF_CTR_BITS 44

// cycles between periodic report strobes, counted 0..period
`define PERF_REPORT_PERIOD 10000

`endif

// ==== hw/perf_pkg.sv ====
/*
 * Shared types for the memory performance monitor.
 * Widths come from perf_cfg.svh; change the macros there,
 * not the typedefs here.
 */

`default_nettype none

`include "perf_cfg.svh"

package perf_pkg;

    // bits needed to count 0..lanes inclusive
    localparam int LANE_COUNT_BITS = $clog2(`PERF_DCACHE_NUM_REQS + 1);

    // unsigned, wraps on overflow
    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // one bit per data-cache lane
    typedef logic [`PERF_DCACHE_NUM_REQS-1:0] lane_mask_t;

    typedef logic [LANE_COUNT_BITS-1:0] lane_count_t;

    // per-cycle change in outstanding loads, may go negative
    typedef logic signed [LANE_COUNT_BITS:0] pending_step_t;

endpackage

`default_nettype wire

// ==== hw/ifetch_perf_counter.sv ====
/*
 * Instruction-cache fetch counter and latency accumulator.
 * Passive: only samples valid/ready strobes, drives nothing back.
 * Latency grows each cycle by the reads outstanding before the edge,
 * so the sum over all fetches of their request-to-response cycles.
 * Expects in-order single-beat responses, one per request.
 */

`timescale 1ns/1ps
`default_nettype none

module ifetch_perf_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               icache_req_valid,
    input  logic               icache_req_ready,
    input  logic               icache_rsp_valid,
    input  logic               icache_rsp_ready,
    output perf_pkg::perf_ctr_t ifetches,
    output perf_pkg::perf_ctr_t ifetch_latency
);

    logic              req_fire;
    logic              rsp_fire;
    logic signed [1:0] pending_step;

    perf_pkg::perf_ctr_t ifetch_pending;

    assign req_fire = icache_req_valid && icache_req_ready;
    assign rsp_fire = icache_rsp_valid && icache_rsp_ready;

    // +1, 0 or -1 this cycle
    assign pending_step = $signed({1'b0, req_fire}) - $signed({1'b0, rsp_fire});

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_pending <= '0;
        end else begin
            // signed step sign-extends into the counter width
            ifetch_pending <= ifetch_pending + perf_pkg::perf_ctr_t'(pending_step);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches       <= '0;
            ifetch_latency <= '0;
        end else begin
            ifetches       <= ifetches + perf_pkg::perf_ctr_t'(req_fire);
            // pending value from before this edge
            ifetch_latency <= ifetch_latency + ifetch_pending;
        end
    end

    // a response needs a fetch in flight or one going out this cycle
    rsp_has_fetch: assert property (
        @(posedge clk) disable iff (reset)
        rsp_fire |-> (ifetch_pending != '0) || req_fire
    ) else $error("icache response with no fetch outstanding");

endmodule

`default_nettype wire

// ==== hw/dcache_perf_counter.sv ====
/*
 * Data-cache load/store counters and load latency accumulator.
 * Request fire masks are registered once, so loads and stores
 * appear one cycle after their fire cycle. Responses are counted
 * without delay and are all treated as load responses; stores are
 * assumed to return no response that reaches this port.
 */

`timescale 1ns/1ps
`default_nettype none

`include "perf_cfg.svh"

module dcache_perf_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  perf_pkg::lane_mask_t dcache_req_valid,
    input  perf_pkg::lane_mask_t dcache_req_ready,
    input  perf_pkg::lane_mask_t dcache_req_rw,
    input  perf_pkg::lane_mask_t dcache_rsp_valid,
    input  perf_pkg::lane_mask_t dcache_rsp_ready,
    output perf_pkg::perf_ctr_t  loads,
    output perf_pkg::perf_ctr_t  stores,
    output perf_pkg::perf_ctr_t  load_latency
);

    perf_pkg::lane_mask_t    ld_fire;
    perf_pkg::lane_mask_t    st_fire;
    perf_pkg::lane_mask_t    rsp_fire;
    perf_pkg::lane_mask_t    ld_fire_r;
    perf_pkg::lane_mask_t    st_fire_r;
    perf_pkg::lane_count_t   ld_cnt;
    perf_pkg::lane_count_t   st_cnt;
    perf_pkg::lane_count_t   rsp_cnt;
    perf_pkg::pending_step_t load_step;
    perf_pkg::perf_ctr_t     load_pending;

    function automatic perf_pkg::lane_count_t popcount(input perf_pkg::lane_mask_t mask);
        perf_pkg::lane_count_t cnt;
        cnt = '0;
        for (int i = 0; i < `PERF_DCACHE_NUM_REQS; i++) begin
            cnt = cnt + perf_pkg::lane_count_t'(mask[i]);
        end
        return cnt;
    endfunction

    // rw high marks a store
    assign ld_fire  = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
    assign st_fire  = dcache_req_valid & dcache_req_ready & dcache_req_rw;
    assign rsp_fire = dcache_rsp_valid & dcache_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_fire_r <= '0;
            st_fire_r <= '0;
        end else begin
            ld_fire_r <= ld_fire;
            st_fire_r <= st_fire;
        end
    end

    assign ld_cnt  = popcount(ld_fire_r);
    assign st_cnt  = popcount(st_fire_r);
    assign rsp_cnt = popcount(rsp_fire);

    // delayed load issues against same-cycle responses
    assign load_step = $signed({1'b0, ld_cnt}) - $signed({1'b0, rsp_cnt});

    always_ff @(posedge clk) begin
        if (reset) begin
            load_pending <= '0;
            loads        <= '0;
            stores       <= '0;
            load_latency <= '0;
        end else begin
            load_pending <= load_pending + perf_pkg::perf_ctr_t'(load_step);
            loads        <= loads + perf_pkg::perf_ctr_t'(ld_cnt);
            stores       <= stores + perf_pkg::perf_ctr_t'(st_cnt);
            load_latency <= load_latency + load_pending;
        end
    end

    // the delayed mask lets a response arrive one cycle after its request
    // and still be matched, otherwise pending would underflow
    rsp_within_pending: assert property (
        @(posedge clk) disable iff (reset)
        perf_pkg::perf_ctr_t'(rsp_cnt) <= load_pending + perf_pkg::perf_ctr_t'(ld_cnt)
    ) else $error("dcache responses exceed outstanding loads");

endmodule

`default_nettype wire

// ==== hw/perf_report_timer.sv ====
/*
 * Report strobe for the performance monitor.
 * Pulses for one cycle when busy falls and each time the period
 * counter sits at zero, so first in the cycle after reset and then
 * every REPORT_PERIOD+1 cycles. REPORT_PERIOD must be positive.
 * The strobe is held low while reset is asserted.
 */

`timescale 1ns/1ps
`default_nettype none

`include "perf_cfg.svh"

module perf_report_timer #(
    parameter int REPORT_PERIOD = `PERF_REPORT_PERIOD
) (
    input  logic clk,
    input  logic reset,
    input  logic busy,
    output logic report
);

    localparam int CNT_BITS = $clog2(REPORT_PERIOD + 1);

    logic                busy_prev;
    logic [CNT_BITS-1:0] period_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_prev  <= 1'b0;
            period_cnt <= '0;
        end else begin
            busy_prev <= busy;
            // counts 0..REPORT_PERIOD inclusive
            if (period_cnt == CNT_BITS'(REPORT_PERIOD)) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + CNT_BITS'(1);
            end
        end
    end

    assign report = !reset && ((period_cnt == '0) || (busy_prev && !busy));

    period_in_range: assert property (
        @(posedge clk) disable iff (reset)
        period_cnt <= CNT_BITS'(REPORT_PERIOD)
    ) else $error("report period counter past its wrap value");

endmodule

`default_nettype wire

// ==== hw/core_mem_perf_monitor.sv ====
/*
 * Memory performance monitor for one core.
 * Watches the icache port and every dcache lane, counts fetches,
 * loads and stores, accumulates their latencies and raises a
 * report strobe. Purely passive; bus ready signals are not driven.
 */

`timescale 1ns/1ps
`default_nettype none

`include "perf_cfg.svh"

module core_mem_perf_monitor #(
    parameter int REPORT_PERIOD = `PERF_REPORT_PERIOD
) (
    input  logic                 clk,
    input  logic                 reset,

    // icache port strobes
    input  logic                 icache_req_valid,
    input  logic                 icache_req_ready,
    input  logic                 icache_rsp_valid,
    input  logic                 icache_rsp_ready,

    // dcache lane strobes, one bit per lane
    input  perf_pkg::lane_mask_t dcache_req_valid,
    input  perf_pkg::lane_mask_t dcache_req_ready,
    input  perf_pkg::lane_mask_t dcache_req_rw,
    input  perf_pkg::lane_mask_t dcache_rsp_valid,
    input  perf_pkg::lane_mask_t dcache_rsp_ready,

    input  logic                 busy,

    output perf_pkg::perf_ctr_t  ifetches,
    output perf_pkg::perf_ctr_t  ifetch_latency,
    output perf_pkg::perf_ctr_t  loads,
    output perf_pkg::perf_ctr_t  stores,
    output perf_pkg::perf_ctr_t  load_latency,
    output logic                 report
);

    ifetch_perf_counter u_ifetch (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .ifetches         (ifetches),
        .ifetch_latency   (ifetch_latency)
    );

    dcache_perf_counter u_dcache (
        .clk              (clk),
        .reset            (reset),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .loads            (loads),
        .stores           (stores),
        .load_latency     (load_latency)
    );

    perf_report_timer #(
        .REPORT_PERIOD (REPORT_PERIOD)
    ) u_report (
        .clk    (clk),
        .reset  (reset),
        .busy   (busy),
        .report (report)
    );

endmodule

`default_nettype wire

// ==== bench/core_mem_perf_monitor_tb.sv ====
/*
 * Testbench for the core memory performance monitor.
 * Inputs change on the falling edge; outputs are sampled 1 ns later,
 * against a model stepped on each rising edge. Random stimulus uses
 * $random with a fixed seed. Data-cache responses are limited to the
 * loads the model has outstanding, so the DUT assertions stay quiet.
 */

`timescale 1ns/1ps
`default_nettype none

`include "perf_cfg.svh"

module core_mem_perf_monitor_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int REPORT_PERIOD = 63;
    localparam int LANES         = `PERF_DCACHE_NUM_REQS;
    localparam int N_RANDOM      = 200;
    localparam int N_DRAIN       = 16;
    localparam int N_BUSY        = 128;
    localparam int N_TOGGLE      = 40;
    localparam int TOTAL_CYCLES  = 3 + 32 + N_RANDOM + N_DRAIN + N_BUSY + N_TOGGLE + 8;
    localparam int MARGIN        = 100;

    logic clk = 1'b0;
    logic reset;
    logic icache_req_valid;
    logic icache_req_ready;
    logic icache_rsp_valid;
    logic icache_rsp_ready;
    logic busy;
    logic report;
    perf_pkg::lane_mask_t dcache_req_valid;
    perf_pkg::lane_mask_t dcache_req_ready;
    perf_pkg::lane_mask_t dcache_req_rw;
    perf_pkg::lane_mask_t dcache_rsp_valid;
    perf_pkg::lane_mask_t dcache_rsp_ready;
    perf_pkg::perf_ctr_t  ifetches;
    perf_pkg::perf_ctr_t  ifetch_latency;
    perf_pkg::perf_ctr_t  loads;
    perf_pkg::perf_ctr_t  stores;
    perf_pkg::perf_ctr_t  load_latency;

    // reference model state
    perf_pkg::perf_ctr_t  m_ifetch_pend = '0;
    perf_pkg::perf_ctr_t  m_ifetches = '0;
    perf_pkg::perf_ctr_t  m_ifetch_lat = '0;
    perf_pkg::perf_ctr_t  m_ld_pend = '0;
    perf_pkg::perf_ctr_t  m_loads = '0;
    perf_pkg::perf_ctr_t  m_stores = '0;
    perf_pkg::perf_ctr_t  m_load_lat = '0;
    perf_pkg::lane_mask_t m_ld_r = '0;
    perf_pkg::lane_mask_t m_st_r = '0;
    logic                 m_busy_prev = 1'b0;
    int                   m_period = 0;

    int seed = 32'hfbaf;
    int n_checks = 0;
    int n_errors = 0;

    core_mem_perf_monitor #(
        .REPORT_PERIOD (REPORT_PERIOD)
    ) dut0 (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .busy             (busy),
        .ifetches         (ifetches),
        .ifetch_latency   (ifetch_latency),
        .loads            (loads),
        .stores           (stores),
        .load_latency     (load_latency),
        .report           (report)
    );

    initial begin
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // one rising edge of the counter rules, from the inputs of the cycle just ended
    function automatic void step_model();
        perf_pkg::lane_mask_t ld_now;
        perf_pkg::lane_mask_t st_now;
        perf_pkg::lane_mask_t rsp_now;
        logic                 req_fire;
        logic                 rsp_fire;
        ld_now   = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
        st_now   = dcache_req_valid & dcache_req_ready & dcache_req_rw;
        rsp_now  = dcache_rsp_valid & dcache_rsp_ready;
        req_fire = icache_req_valid & icache_req_ready;
        rsp_fire = icache_rsp_valid & icache_rsp_ready;
        if (reset) begin
            m_ifetch_pend = '0;
            m_ifetches    = '0;
            m_ifetch_lat  = '0;
            m_ld_pend     = '0;
            m_loads       = '0;
            m_stores      = '0;
            m_load_lat    = '0;
            m_ld_r        = '0;
            m_st_r        = '0;
            m_busy_prev   = 1'b0;
            m_period      = 0;
        end else begin
            m_ifetch_lat  = m_ifetch_lat + m_ifetch_pend;
            m_ifetches    = m_ifetches + perf_pkg::perf_ctr_t'(req_fire);
            m_ifetch_pend = m_ifetch_pend + perf_pkg::perf_ctr_t'(req_fire)
                            - perf_pkg::perf_ctr_t'(rsp_fire);
            m_load_lat    = m_load_lat + m_ld_pend;
            m_loads       = m_loads + perf_pkg::perf_ctr_t'($countones(m_ld_r));
            m_stores      = m_stores + perf_pkg::perf_ctr_t'($countones(m_st_r));
            m_ld_pend     = m_ld_pend + perf_pkg::perf_ctr_t'($countones(m_ld_r))
                            - perf_pkg::perf_ctr_t'($countones(rsp_now));
            m_ld_r        = ld_now;
            m_st_r        = st_now;
            m_busy_prev   = busy;
            m_period      = (m_period == REPORT_PERIOD) ? 0 : m_period + 1;
        end
    endfunction

    always @(posedge clk) begin
        step_model();
    end

    task automatic compare_value(input string name, input perf_pkg::perf_ctr_t expected,
                                 input perf_pkg::perf_ctr_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        logic exp_report;
        #1;
        if (!reset) begin
            exp_report = (m_period == 0) || (m_busy_prev && !busy);
            compare_value("ifetches", m_ifetches, ifetches);
            compare_value("ifetch_latency", m_ifetch_lat, ifetch_latency);
            compare_value("loads", m_loads, loads);
            compare_value("stores", m_stores, stores);
            compare_value("load_latency", m_load_lat, load_latency);
            compare_value("report", perf_pkg::perf_ctr_t'(exp_report),
                          perf_pkg::perf_ctr_t'(report));
        end
    end

    // bits are {req_valid, req_ready, rsp_valid, rsp_ready}
    task automatic drive_icache(input logic [3:0] strobes);
        @(negedge clk);
        {icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready} = strobes;
    endtask

    // one stalled cycle, then a fetch whose response fires n cycles later
    task automatic fetch_once(input int n);
        drive_icache(4'b1000);
        drive_icache(4'b1100);
        repeat (n - 1) drive_icache(4'b0000);
        drive_icache(4'b0011);
        drive_icache(4'b0000);
    endtask

    task automatic drive_dcache_cycle(input logic new_requests);
        int                   budget;
        perf_pkg::lane_mask_t rsp_valid;
        @(negedge clk);
        // responses may not outrun loads in flight plus those registered this cycle
        budget = int'(m_ld_pend) + $countones(m_ld_r);
        dcache_req_valid = new_requests ? perf_pkg::lane_mask_t'($random(seed)) : '0;
        dcache_req_ready = perf_pkg::lane_mask_t'($random(seed));
        dcache_req_rw    = perf_pkg::lane_mask_t'($random(seed));
        dcache_rsp_ready = perf_pkg::lane_mask_t'($random(seed));
        rsp_valid        = perf_pkg::lane_mask_t'($random(seed));
        for (int i = 0; i < LANES; i++) begin
            if (rsp_valid[i] && dcache_rsp_ready[i]) begin
                if (budget > 0) begin
                    budget--;
                end else begin
                    rsp_valid[i] = 1'b0;
                end
            end
        end
        dcache_rsp_valid = rsp_valid;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        {icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready} = 4'b0000;
        dcache_req_valid = '0;
        dcache_req_ready = '0;
        dcache_req_rw    = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
    endtask

    initial begin
        int pulses;
        reset = 1'b1;
        busy  = 1'b0;
        {icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready} = 4'b0000;
        dcache_req_valid = '0;
        dcache_req_ready = '0;
        dcache_req_rw    = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        if (report !== 1'b1) begin
            n_errors++;
            $display("error at %0t: report did not pulse in the first cycle after reset", $time);
        end

        fetch_once(1);
        fetch_once(6);
        // three overlapping fetches, one response held off by ready
        drive_icache(4'b1100);
        drive_icache(4'b0000);
        drive_icache(4'b1100);
        drive_icache(4'b0010);
        drive_icache(4'b1111);
        drive_icache(4'b0000);
        drive_icache(4'b0011);
        drive_icache(4'b0011);
        idle_cycle();

        repeat (N_RANDOM) drive_dcache_cycle(1'b1);
        repeat (N_DRAIN) drive_dcache_cycle(1'b0);
        idle_cycle();

        // with busy steady high only the period pulses remain
        busy   = 1'b1;
        pulses = 0;
        repeat (N_BUSY) begin
            #1;
            if (report) begin
                pulses++;
            end
            @(negedge clk);
        end
        if (pulses != N_BUSY / (REPORT_PERIOD + 1)) begin
            n_errors++;
            $display("error at %0t: report pulsed %0d times in %0d busy cycles, expected %0d",
                     $time, pulses, N_BUSY, N_BUSY / (REPORT_PERIOD + 1));
        end
        busy = 1'b0;
        #1;
        if (report !== 1'b1) begin
            n_errors++;
            $display("error at %0t: report stayed low when busy fell", $time);
        end

        repeat (N_TOGGLE) begin
            @(negedge clk);
            busy = 1'($random(seed));
        end
        idle_cycle();
        repeat (4) @(negedge clk);
        #2;
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN));
        $display("timeout: stimulus did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/perf_pkg.sv
hw/ifetch_perf_counter.sv
hw/dcache_perf_counter.sv
hw/perf_report_timer.sv
hw/core_mem_perf_monitor.sv
bench/core_mem_perf_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the monitor testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=core_mem_perf_monitor_tb

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module "$TOP" --Mdir "$BUILD_DIR" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -qx "test passed" "$SIM_LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
